/* verilog.f */
hdl/life_pkg.sv
hdl/button_debounce.sv
hdl/gen_sequencer.sv
hdl/cell_addr_pipe.sv
hdl/init_loader.sv
hdl/life_ctrl_top.sv
bench/life_ctrl_properties.sv
bench/life_ctrl_tb.sv

/* Makefile */
SRCS := $(shell cat verilog.f)

.PHONY: run clean

obj_dir/Vlife_ctrl_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module life_ctrl_tb -f verilog.f

run: obj_dir/Vlife_ctrl_tb
	@out="$$(./obj_dir/Vlife_ctrl_tb 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* bench/life_ctrl_tb.sv */
// Testbench for the life control top level
// Clock, reset, button and video stimulus, reference models, comparing process

`timescale 1ns/1ps

module life_ctrl_tb;

	import life_pkg::*;

	localparam logic [255:0] TAP_MASK = (256'd1 << 253) | (256'd1 << 250) | (256'd1 << 245);
	localparam int VIDEO_PULSES = 20;

	logic                 clk4 = 1'b0;
	logic                 reset;
	logic                 fire_button;
	cell_addr_u           vraddr;
	logic                 vload;
	nbr_addr_t            raddr;
	ram_cmd_t             cmd;
	logic [GEN_BITS-1:0]  gen_count;

	integer seed = 26908;

	// Model state, owned by the comparing process
	logic [255:0] lfsr_m;		// DUT LFSR as of this cycle
	logic         lfsr_prev;	// Bit 0 one cycle back
	logic         started;
	int           cyc;		// Cycles since reset release
	int           init_writes;
	int           last_init_cyc;
	int           init_fall_cyc;
	int           gen_writes;
	int           gens_seen;
	int           ld_seen;
	logic [3:0]   tb_base;	// Read base of the running generation
	nbr_addr_t    raddr_hist [0:7];
	logic         vl_hist [0:7];
	cell_addr_u   va_hist [0:7];

	life_ctrl_top #(
		.PRESS_CYCLES  (8),
		.PULSE_CYCLES  (20),
		.LONG_CYCLES   (200),
		.RELEASE_CYCLES(40),
		.INIT_STEP_BITS(2)
	) DUT (
		.clk4       (clk4),
		.reset      (reset),
		.fire_button(fire_button),
		.vraddr     (vraddr),
		.vload      (vload),
		.raddr      (raddr),
		.cmd        (cmd),
		.gen_count  (gen_count)
	);

	bind life_ctrl_top life_ctrl_properties props (
		.clk4 (clk4),
		.reset(reset),
		.vload(vload),
		.raddr(raddr),
		.cmd  (cmd)
	);

	always #2 clk4 = ~clk4;	// 4 ns period

	////////////////////
	// Reference models
	function automatic logic [255:0] lfsr_next(logic [255:0] s);
		logic [255:0] n;
		n = s >> 1;
		n[255] = s[0];	// Feedback into the top
		if (s[0])
			n = n ^ TAP_MASK;
		return n;
	endfunction

	// Logical row to physical row for a given base
	function automatic logic [3:0] remap_row(logic [3:0] row, logic [3:0] b);
		int d;
		if (row == 4'd0)
			return b[0] ? 4'hf : 4'h0;	// Spare row by parity
		d = int'(row) - int'(b);
		if (d <= 0)
			d = d + HEIGHT_B;
		return 4'(d);
	endfunction

	// One neighbour of a cell, offsets -1..1
	function automatic cell_addr_u expected_addr(logic [3:0] row, logic [3:0] col,
			logic [3:0] b, int dr, int dc);
		cell_addr_u a;
		a.rc.row = remap_row(4'(int'(row) + dr), b);
		a.rc.col = 4'(int'(col) + dc);
		return a;
	endfunction

	task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
		$display("** Error %s: expected %0h, actual %0h", name, exp, act);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_problem(string msg);
		$display("Problem: %s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	////////////////////
	// Comparing process, samples mid-cycle
	always @(negedge clk4) begin
		cell_addr_u exp_a;
		int         idx;
		if (reset) begin
			started = 1'b0;
			cyc = 0;
			init_writes = 0;
			last_init_cyc = 0;
			init_fall_cyc = -1;
			gen_writes = 0;
			gens_seen = 0;
			ld_seen = 0;
			tb_base = 4'd1;	// Base after reset
			for (int i = 0; i < 8; i++) begin
				raddr_hist[i] = '0;
				vl_hist[i] = 1'b0;
				va_hist[i] = '0;
			end
		end else begin
			if (!started) begin
				started = 1'b1;
				lfsr_m = LFSR_SEED;
				lfsr_prev = LFSR_SEED[0];
			end else begin
				lfsr_prev = lfsr_m[0];
				lfsr_m = lfsr_next(lfsr_m);
			end
			for (int i = 7; i > 0; i--) begin
				raddr_hist[i] = raddr_hist[i-1];
				vl_hist[i] = vl_hist[i-1];
				va_hist[i] = va_hist[i-1];
			end
			raddr_hist[0] = raddr;
			vl_hist[0] = vload;
			va_hist[0] = vraddr;

			// Video load strobe, fixed latency
			assert (cmd.ld == vl_hist[LD_DELAY]) else
				report_mismatch("video ld", vl_hist[LD_DELAY], cmd.ld);
			if (cmd.ld)
				ld_seen++;
			if (vl_hist[ROW_PIPE]) begin
				exp_a = expected_addr(va_hist[ROW_PIPE].rc.row, va_hist[ROW_PIPE].rc.col,
						tb_base, 0, 0);
				assert (raddr[1][1] == exp_a) else
					report_mismatch("video raddr", exp_a, raddr[1][1]);
			end

			if (cmd.we && cmd.init) begin
				assert (cmd.waddr.flat == 8'(init_writes)) else
					report_mismatch("init waddr", init_writes, cmd.waddr.flat);
				assert (cmd.init_data == lfsr_prev) else
					report_mismatch("init data", lfsr_prev, cmd.init_data);
				if (init_writes > 0)
					assert (cyc - last_init_cyc == 4) else
						report_mismatch("init spacing", 4, cyc - last_init_cyc);
				last_init_cyc = cyc;
				init_writes++;
			end else if (cmd.we) begin
				idx = gen_writes % 256;
				exp_a = expected_addr(4'(idx >> 4), 4'(idx), tb_base + 4'd1, 0, 0);
				assert (cmd.waddr == exp_a) else
					report_mismatch("write addr", exp_a, cmd.waddr);
				// Neighbourhood read 6 cycles before this write
				for (int r = 0; r < 3; r++) begin
					for (int c = 0; c < 3; c++) begin
						exp_a = expected_addr(4'(idx >> 4), 4'(idx), tb_base, r - 1, c - 1);
						assert (raddr_hist[WRITE_DELAY][r][c] == exp_a) else
							report_mismatch("read addr", exp_a,
									raddr_hist[WRITE_DELAY][r][c]);
					end
				end
				gen_writes++;
				if (idx == 255) begin
					tb_base = tb_base + 4'd1;
					gens_seen++;
				end
			end

			if (!cmd.init && init_fall_cyc < 0) begin
				init_fall_cyc = cyc;
				assert (init_writes == 256) else
					report_mismatch("init write count", 256, init_writes);
				assert (cyc >= 2048 && cyc <= 2052) else
					report_mismatch("init length", 2048, cyc);
			end
			cyc++;
		end
	end

	////////////////////
	// Waits, each with its own limit
	task automatic wait_init_done(int limit);
		int n;
		n = 0;
		while (init_fall_cyc < 0) begin
			if (n >= limit)
				report_problem("init never fell");
			@(posedge clk4);
			n++;
		end
	endtask

	task automatic wait_writes(int target, int limit);
		int n;
		n = 0;
		while (gen_writes < target) begin
			if (n >= limit)
				report_problem("generation writes stopped early");
			@(posedge clk4);
			n++;
		end
	endtask

	// Returns once no write has come for a while
	task automatic wait_quiet(int quiet, int limit);
		int n;
		int q;
		int w;
		n = 0;
		q = 0;
		w = gen_writes;
		while (q < quiet) begin
			if (n >= limit)
				report_problem("sequencer did not return to idle");
			@(posedge clk4);
			n++;
			if (gen_writes != w) begin
				w = gen_writes;
				q = 0;
			end else begin
				q++;
			end
		end
	endtask

	task automatic press_button(int hold);
		@(posedge clk4);
		fire_button <= 1'b1;
		repeat (hold) @(posedge clk4);
		fire_button <= 1'b0;
	endtask

	////////////////////
	// Stimulus
	initial begin
		logic [GEN_BITS-1:0] g0;
		int                  w0;
		int                  gs0;
		int                  c0;
		int                  gap;
		reset = 1'b1;
		fire_button = 1'b0;
		vraddr = '0;
		vload = 1'b0;
		repeat (5) @(posedge clk4);
		reset <= 1'b0;

		// Start-up load
		wait_init_done(3000);

		// Short press, one generation
		g0 = gen_count;
		w0 = gen_writes;
		press_button(40);
		wait_writes(w0 + 256, 1000);
		wait_quiet(150, 1000);
		assert (gen_writes == w0 + 256) else
			report_mismatch("short press writes", w0 + 256, gen_writes);
		assert (gen_count == g0 + 1) else
			report_mismatch("short press gen_count", g0 + 1, gen_count);

		// Long hold, back to back generations
		g0 = gen_count;
		w0 = gen_writes;
		gs0 = gens_seen;
		@(posedge clk4);
		fire_button <= 1'b1;
		wait_writes(w0 + 1, 500);
		c0 = cyc;
		wait_writes(w0 + 1 + 3 * 256, 2000);
		assert (cyc - c0 == 3 * 256) else
			report_mismatch("long hold gaps", 3 * 256, cyc - c0);
		fire_button <= 1'b0;
		wait_quiet(150, 2000);
		// Release timeout ends well inside the fourth generation
		assert (gens_seen - gs0 == 4) else
			report_mismatch("long hold generations", 4, gens_seen - gs0);
		assert (gen_count == g0 + 4) else
			report_mismatch("long hold gen_count", g0 + 4, gen_count);

		// Video port while idle
		ld_seen = 0;
		for (int i = 0; i < VIDEO_PULSES; i++) begin
			gap = 6 + ($random(seed) & 7);
			repeat (gap) @(posedge clk4);
			vraddr <= 8'($random(seed));
			vload <= 1'b1;
			@(posedge clk4);
			vload <= 1'b0;
		end
		repeat (8) @(posedge clk4);	// Drain the load delay
		assert (ld_seen == VIDEO_PULSES) else
			report_mismatch("video ld count", VIDEO_PULSES, ld_seen);

		$display(">>> PASS");
		$finish;
	end

endmodule

/* bench/life_ctrl_properties.sv */
// Bound assertions for the life control top level
// Load delay, column neighbours, strobes after reset

`timescale 1ns/1ps

module life_ctrl_properties (
	input logic                clk4,
	input logic                reset,
	input logic                vload,
	input life_pkg::nbr_addr_t raddr,
	input life_pkg::ram_cmd_t  cmd
);

	import life_pkg::*;

	// ld is vload five cycles late
	ld_delay: assert property (@(posedge clk4) disable iff (reset)
		cmd.ld == $past(vload, LD_DELAY))
		else $error("ld does not follow vload by five cycles");

	// Side columns sit one either side of the centre, wrapping
	for (genvar r = 0; r < 3; r++) begin : g_cols
		left_col: assert property (@(posedge clk4) disable iff (reset)
			raddr[r][0].rc.col == raddr[r][1].rc.col - 4'd1)
			else $error("left column not centre minus one");
		right_col: assert property (@(posedge clk4) disable iff (reset)
			raddr[r][2].rc.col == raddr[r][1].rc.col + 4'd1)
			else $error("right column not centre plus one");
	end

	////////////////////
	// Quiet strobes around reset
	quiet_in_reset: assert property (@(posedge clk4) reset |=> !cmd.we && !cmd.ld)
		else $error("strobe active right after reset");

	quiet_at_release: assert property (@(posedge clk4) $fell(reset) |-> !cmd.we && !cmd.ld)
		else $error("strobe active at reset release");

endmodule

/* hdl/life_ctrl_top.sv */
// Life control top level
// Debounce, sequencer, address pipeline and start-up loader

`timescale 1ns/1ps

module life_ctrl_top #(
	parameter int unsigned PRESS_CYCLES   = 960_000,
	parameter int unsigned PULSE_CYCLES   = 4_800_000,
	parameter int unsigned LONG_CYCLES    = 8_388_608,
	parameter int unsigned RELEASE_CYCLES = 19_200_000,
	parameter int          INIT_STEP_BITS = 12
) (
	input  logic                          clk4,
	input  logic                          reset,
	input  logic                          fire_button,
	input  life_pkg::cell_addr_u          vraddr,
	input  logic                          vload,
	output life_pkg::nbr_addr_t           raddr,
	output life_pkg::ram_cmd_t            cmd,
	output logic [life_pkg::GEN_BITS-1:0] gen_count
);

	import life_pkg::*;

	logic               short_fire;
	logic               long_fire;
	logic [ADDR_BITS:0] read_cnt;
	logic [3:0]         base;
	logic               we_init;
	cell_addr_u         init_waddr;
	logic               init;
	logic               init_data;

	button_debounce #(
		.PRESS_CYCLES  (PRESS_CYCLES),
		.PULSE_CYCLES  (PULSE_CYCLES),
		.LONG_CYCLES   (LONG_CYCLES),
		.RELEASE_CYCLES(RELEASE_CYCLES)
	) u_debounce (
		.clk4       (clk4),
		.reset      (reset),
		.fire_button(fire_button),
		.short_fire (short_fire),
		.long_fire  (long_fire)
	);

	gen_sequencer u_seq (
		.clk4      (clk4),
		.reset     (reset),
		.short_fire(short_fire),
		.long_fire (long_fire),
		.read_cnt  (read_cnt),
		.base      (base),
		.gen_count (gen_count)
	);

	// Seeding writes merge into cmd inside the pipeline
	init_loader #(
		.INIT_STEP_BITS(INIT_STEP_BITS)
	) u_loader (
		.clk4      (clk4),
		.reset     (reset),
		.we_init   (we_init),
		.init_waddr(init_waddr),
		.init      (init),
		.init_data (init_data)
	);

	cell_addr_pipe u_pipe (
		.clk4      (clk4),
		.reset     (reset),
		.read_cnt  (read_cnt),
		.base      (base),
		.vraddr    (vraddr),
		.vload     (vload),
		.we_init   (we_init),
		.init_waddr(init_waddr),
		.init      (init),
		.init_data (init_data),
		.raddr     (raddr),
		.cmd       (cmd)
	);

endmodule

/* hdl/init_loader.sv */
// Start-up loader
// Phase counter, row write strobes and LFSR seed data

`timescale 1ns/1ps

module init_loader #(
	parameter int INIT_STEP_BITS = 12	// Cycles per step, as a power of two
) (
	input  logic                 clk4,
	input  logic                 reset,
	output logic                 we_init,	// Seed row write
	output life_pkg::cell_addr_u init_waddr,
	output logic                 init,		// High until seeding is over
	output logic                 init_data	// Serial seed bit
);

	import life_pkg::*;

	// 512 steps, top bit marks the end
	localparam int CNT_BITS = INIT_STEP_BITS + 10;
	localparam logic [CNT_BITS-1:0] CNT_END = CNT_BITS'(1) << (INIT_STEP_BITS + 9);

	logic [CNT_BITS-1:0] init_cnt;
	logic                load_phase;
	logic                step_last;
	logic [255:0]        lfsr;

	// Runs once after reset, then parks
	always_ff @(posedge clk4) begin
		if (reset)
			init_cnt <= '0;
		else if (init_cnt != CNT_END)
			init_cnt <= init_cnt + 1'b1;
	end

	assign load_phase = (init_cnt[CNT_BITS-1 -: 2] == 2'b01);	// Second 256 steps
	assign step_last  = &init_cnt[INIT_STEP_BITS-1:0];

	////////////////////
	// Strobes
	always_ff @(posedge clk4) begin
		if (reset) begin
			we_init <= 1'b0;
			init    <= 1'b1;
		end else begin
			we_init <= load_phase & step_last;
			init    <= (init_cnt != CNT_END);
		end
	end

	// Step number is the row written
	always_ff @(posedge clk4) begin
		init_waddr.flat <= init_cnt[INIT_STEP_BITS +: ADDR_BITS];
	end

	// Seed LFSR, taps 255 253 250 245, shifts right every cycle
	always_ff @(posedge clk4) begin
		if (reset) begin
			lfsr <= LFSR_SEED;
		end else begin
			lfsr <= {lfsr[0],
				lfsr[255],
				lfsr[254] ^ lfsr[0],	// Tap 253
				lfsr[253:252],
				lfsr[251] ^ lfsr[0],	// Tap 250
				lfsr[250:247],
				lfsr[246] ^ lfsr[0],	// Tap 245
				lfsr[245:1]};
		end
	end

	assign init_data = lfsr[0];

endmodule

/* hdl/cell_addr_pipe.sv */
// Cell address pipeline
// Row remap lanes, column path, nine read addresses, write and load delays

`timescale 1ns/1ps

module cell_addr_pipe (
	input  logic                         clk4,
	input  logic                         reset,
	input  logic [life_pkg::ADDR_BITS:0] read_cnt,
	input  logic [3:0]                   base,
	input  life_pkg::cell_addr_u         vraddr,	// Video read address
	input  logic                         vload,	// Video read strobe
	input  logic                         we_init,
	input  life_pkg::cell_addr_u         init_waddr,
	input  logic                         init,
	input  logic                         init_data,
	output life_pkg::nbr_addr_t          raddr,
	output life_pkg::ram_cmd_t           cmd
);

	import life_pkg::*;

	localparam int WE_PIPE = ROW_PIPE + WRITE_DELAY - 1;

	logic       idle;
	logic [3:0] row_src;
	logic [3:0] col_src;

	// Lanes 0..2 are row-1, row, row+1, lane 3 is the write row
	logic [3:0][3:0] row_reg;
	logic [3:0][3:0] base_reg;
	logic [3:0][1:0] roweq0;
	logic [3:0][1:0] basebit0;
	logic [3:0][3:0] basesum;
	logic [3:0][3:0] basemod;
	logic [3:0][3:0] adj_row;

	logic [3:0]      col_mux;
	logic [1:0][3:0] col_del;
	logic [2:0][3:0] adj_col;	// col-1, col, col+1

	cell_addr_u                     wslot;
	cell_addr_u [WRITE_DELAY-2:0]   waddr_del;
	logic [WE_PIPE-1:0]             we_del;
	logic [LD_DELAY-1:0]            ld_del;
	logic                           cmd_we;
	cell_addr_u                     cmd_waddr;
	logic                           cmd_init;
	logic                           cmd_init_data;

	// Video address takes the slot while the walk is parked
	assign idle    = (read_cnt == CNT_IDLE);
	assign row_src = idle ? vraddr.rc.row : read_cnt[7:4];
	assign col_src = idle ? vraddr.rc.col : read_cnt[3:0];

	////////////////////
	// Row remap, four stages
	always_ff @(posedge clk4) begin
		row_reg[0]  <= row_src - 4'd1;	// Wraps top to bottom
		row_reg[1]  <= row_src;
		row_reg[2]  <= row_src + 4'd1;
		row_reg[3]  <= row_src;		// Write row
		base_reg[0] <= base;
		base_reg[1] <= base;
		base_reg[2] <= base;
		base_reg[3] <= base + 4'd1;	// Next generation's base
		for (int ii = 0; ii < 4; ii++) begin
			roweq0[ii][0]   <= (row_reg[ii] == 4'd0);
			roweq0[ii][1]   <= roweq0[ii][0];
			basebit0[ii][0] <= base_reg[ii][0];
			basebit0[ii][1] <= basebit0[ii][0];
			// Four-bit wrap adds the full arena on zero or below
			basesum[ii]     <= row_reg[ii] - base_reg[ii];
			basemod[ii]     <= basesum[ii];	// Matched to the parity path
			// Row 0 lives in the spare row picked by base parity
			adj_row[ii] <= roweq0[ii][1] ? (basebit0[ii][1] ? 4'hf : 4'h0) :
					basemod[ii];
		end
	end

	// Column path, depth matched to the rows
	always_ff @(posedge clk4) begin
		col_mux    <= col_src;
		col_del[0] <= col_mux;
		col_del[1] <= col_del[0];
		adj_col[0] <= col_del[1] - 4'd1;	// Wraps left edge
		adj_col[1] <= col_del[1];
		adj_col[2] <= col_del[1] + 4'd1;
	end

	// Nine neighbourhood addresses
	for (genvar r = 0; r < 3; r++) begin : g_row
		for (genvar c = 0; c < 3; c++) begin : g_col
			assign raddr[r][c].rc.row = adj_row[r];
			assign raddr[r][c].rc.col = adj_col[c];
		end
	end

	////////////////////
	// Write slot
	assign wslot.rc.row = adj_row[3];
	assign wslot.rc.col = adj_col[1];

	// Address delay, last stage is the output register
	always_ff @(posedge clk4) begin
		waddr_del     <= {waddr_del[WRITE_DELAY-3:0], wslot};
		cmd_waddr     <= we_init ? init_waddr : waddr_del[WRITE_DELAY-2];
		cmd_init_data <= init_data;
	end

	// Strobes, both through the full read and write latency
	always_ff @(posedge clk4) begin
		if (reset) begin
			we_del   <= '0;
			cmd_we   <= 1'b0;
			ld_del   <= '0;
			cmd_init <= 1'b1;
		end else begin
			we_del   <= {we_del[WE_PIPE-2:0], ~idle};
			cmd_we   <= we_init | we_del[WE_PIPE-1];
			ld_del   <= {ld_del[LD_DELAY-2:0], vload};	// ld is the last tap
			cmd_init <= init;
		end
	end

	assign cmd.we        = cmd_we;
	assign cmd.waddr     = cmd_waddr;
	assign cmd.ld        = ld_del[LD_DELAY-1];
	assign cmd.init      = cmd_init;
	assign cmd.init_data = cmd_init_data;

endmodule

/* hdl/gen_sequencer.sv */
// Generation sequencer
// Block read counter, base row rotation and generation counter

`timescale 1ns/1ps

module gen_sequencer (
	input  logic                           clk4,
	input  logic                           reset,
	input  logic                           short_fire,	// One generation
	input  logic                           long_fire,	// Run continuously
	output logic [life_pkg::ADDR_BITS:0]   read_cnt,
	output logic [3:0]                     base,
	output logic [life_pkg::GEN_BITS-1:0]  gen_count
);

	import life_pkg::*;

	localparam logic [ADDR_BITS:0] DONE_CNT = (ADDR_BITS + 1)'(WIDTH_B * HEIGHT_B - 1);

	logic go;
	logic go_pend;	// Press seen mid-generation
	logic at_idle;
	logic at_done;
	logic gen_tick;

	assign at_idle = (read_cnt == CNT_IDLE);
	assign at_done = (read_cnt == DONE_CNT);
	assign go = short_fire | long_fire | go_pend;

	////////////////////
	// Block walk
	always_ff @(posedge clk4) begin
		if (reset) begin
			read_cnt <= CNT_IDLE;
			base     <= 4'd1;	// Row 0 parks at base 1
			go_pend  <= 1'b0;
		end else begin
			if (at_idle || at_done)
				read_cnt <= go ? '0 : CNT_IDLE;	// Start or restart
			else
				read_cnt <= read_cnt + 1'b1;

			// Rotate base after the last block
			if (at_done)
				base <= base + 4'd1;	// Wraps to row 0 after row 15

			// Hold a short press until the walk can take it
			go_pend <= (at_idle || at_done) ? 1'b0 : (go_pend | short_fire);
		end
	end

	// Completed generations, two cycles after the last block
	always_ff @(posedge clk4) begin
		if (reset) begin
			gen_tick  <= 1'b0;
			gen_count <= '0;
		end else begin
			gen_tick <= at_done;
			if (gen_tick)
				gen_count <= gen_count + 1'b1;
		end
	end

endmodule

/* hdl/button_debounce.sv */
// Fire button debounce
// Synchroniser, press/long-hold FSM and one-shot pulse former

`timescale 1ns/1ps

module button_debounce #(
	parameter int unsigned PRESS_CYCLES   = 960_000,	// 5 ms at 192 MHz
	parameter int unsigned PULSE_CYCLES   = 4_800_000,	// Pulse ends 25 ms after press
	parameter int unsigned LONG_CYCLES    = 8_388_608,	// About 44 ms to long hold
	parameter int unsigned RELEASE_CYCLES = 19_200_000	// 100 ms release timeout
) (
	input  logic clk4,
	input  logic reset,
	input  logic fire_button,	// Raw pad level, async
	output logic short_fire,	// One cycle per press
	output logic long_fire		// Level while held long
);

	localparam int C1_W = $clog2(LONG_CYCLES + 1);
	localparam int C0_W = $clog2(RELEASE_CYCLES + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PRESS,	// Waiting for stable press
		S_PULSE,	// Debounced output high
		S_WAIT_LONG,
		S_LONG,
		S_OFF,		// Released before long hold
		S_LONG_OFF	// Released from long hold
	} state_t;

	state_t          state;
	logic [3:0]      sync_q;	// Metastability chain
	logic            btn;
	logic [C1_W-1:0] count1;	// Time since press
	logic [C0_W-1:0] count0;	// Time since release
	logic            pulse;
	logic            pulse_d;

	// Four flops before the FSM sees the button
	always_ff @(posedge clk4) begin
		sync_q <= {sync_q[2:0], fire_button};
	end
	assign btn = sync_q[3];

	////////////////////
	// Press state machine
	always_ff @(posedge clk4) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:      state <= btn ? S_PRESS : S_IDLE;
				S_PRESS:     state <= !btn ? S_IDLE :
						(count1 == C1_W'(PRESS_CYCLES)) ? S_PULSE : S_PRESS;
				S_PULSE:     state <= (count1 == C1_W'(PULSE_CYCLES)) ? S_WAIT_LONG : S_PULSE;
				S_WAIT_LONG: state <= !btn ? S_OFF :
						(count1 >= C1_W'(LONG_CYCLES)) ? S_LONG : S_WAIT_LONG;
				S_LONG:      state <= !btn ? S_LONG_OFF : S_LONG;
				S_OFF:       state <= btn ? S_WAIT_LONG :
						(count0 == C0_W'(RELEASE_CYCLES)) ? S_IDLE : S_OFF;
				S_LONG_OFF:  state <= btn ? S_LONG :
						(count0 == C0_W'(RELEASE_CYCLES)) ? S_IDLE : S_LONG_OFF;
				default:     state <= S_IDLE;
			endcase
		end
	end

	// Counters, count1 saturates at the long threshold
	always_ff @(posedge clk4) begin
		if (reset) begin
			count1 <= '0;
			count0 <= '0;
		end else begin
			if (state == S_IDLE)
				count1 <= '0;
			else if (count1 != C1_W'(LONG_CYCLES))
				count1 <= count1 + 1'b1;
			count0 <= (state == S_OFF || state == S_LONG_OFF) ? count0 + 1'b1 : '0;
		end
	end

	assign pulse = (state == S_PULSE);	// Debounced output
	assign long_fire = (state == S_LONG) || (state == S_LONG_OFF);

	// Rising edge of the pulse state, one cycle late
	always_ff @(posedge clk4) begin
		if (reset) begin
			pulse_d    <= 1'b0;
			short_fire <= 1'b0;
		end else begin
			pulse_d    <= pulse;
			short_fire <= pulse & ~pulse_d;
		end
	end

endmodule

/* hdl/life_pkg.sv */
// Shared definitions for the life control path
// Arena geometry, pipeline latencies, address union, port structs, LFSR seed

package life_pkg;

	////////////////////
	// Arena geometry
	localparam int WIDTH_B   = 16;	// Blocks across
	localparam int HEIGHT_B  = 16;	// Blocks down
	localparam int ADDR_BITS = 8;	// Flat cell address

	// Read counter parks here between generations
	localparam logic [ADDR_BITS:0] CNT_IDLE = '1;

	////////////////////
	// Pipeline latencies
	localparam int ROW_PIPE    = 4;	// read_cnt to raddr
	localparam int WRITE_DELAY = 6;	// raddr to matching write
	localparam int LD_DELAY    = 5;	// vload to ld

	localparam int GEN_BITS = 48;	// Generation counter

	// Row/column view of a cell address
	typedef struct packed {
		logic [3:0] row;	// Block row, high nibble
		logic [3:0] col;	// Block column, low nibble
	} cell_rc_t;

	// Same word seen as RAM address or as row/col pair
	typedef union packed {
		logic [ADDR_BITS-1:0] flat;
		cell_rc_t             rc;
	} cell_addr_u;

	// 3x3 neighbourhood, [row offset][col offset]
	typedef cell_addr_u [2:0][2:0] nbr_addr_t;

	// Write and load controls towards the compute array
	typedef struct packed {
		logic       we;		// Write strobe
		cell_addr_u waddr;	// Write address
		logic       ld;		// Video row load
		logic       init;		// Start-up seeding active
		logic       init_data;	// Seed bit
	} ram_cmd_t;

	// Nonzero start of the 256-bit seeding LFSR
	localparam logic [255:0] LFSR_SEED = {
		64'hB058_C13A_506F_8270,
		64'hDB09_5DF2_B81F_FC1F,
		64'h2FD9_C937_6A4E_B19F,
		64'h72B1_3618_9D2C_5321
	};

endpackage
